//--- fc_pkg.sv
`default_nettype none

package fc_pkg;

    // Lanes packed into one 32-bit memory word
    localparam int LANES = 4;

    // Load port and memory address width
    localparam int ADDR_W = 12;

    // Activation or weight
    typedef logic signed [7:0] int8_t;

    // Lane 0 in the low byte holds the lower input index
    typedef int8_t [LANES-1:0] quad_t;

    // Per neuron bias
    typedef logic signed [15:0] bias_t;

    // Holds 256 full scale products plus bias
    typedef logic signed [23:0] acc_t;

    // Requantization shift
    typedef logic [3:0] shift_t;

    // Load target
    typedef enum logic [1:0] {
        SEL_FEATURE = 2'd0,
        SEL_WEIGHT  = 2'd1,
        SEL_BIAS    = 2'd2
    } mem_sel_t;

endpackage

`default_nettype wire

//--- fc_mem.sv
`timescale 1ns/1ps
`default_nettype none

module fc_mem #(
    parameter int  DEPTH  = 16,
    parameter type word_t = fc_pkg::quad_t
) (
    input  wire                       clk,
    input  wire                       wr_en,
    input  wire  [fc_pkg::ADDR_W-1:0] wr_addr,
    input  wire  word_t               wr_data,
    input  wire                       rd_en,
    input  wire  [fc_pkg::ADDR_W-1:0] rd_addr,
    output word_t                     rd_data
);

    // Index bits actually needed for this depth
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr[IDX_W-1:0]] <= wr_data;
        end
    end

    // Registered read, data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr[IDX_W-1:0]];
        end
    end

    // Upper address bits are dropped above, so they must be zero
    a_wr_range: assert property (@(posedge clk) wr_en |-> (wr_addr < DEPTH))
        else $error("fc_mem write address %0d beyond depth %0d", wr_addr, DEPTH);

    a_rd_range: assert property (@(posedge clk) rd_en |-> (rd_addr < DEPTH))
        else $error("fc_mem read address %0d beyond depth %0d", rd_addr, DEPTH);

endmodule

`default_nettype wire

//--- fc_mac.sv
`timescale 1ns/1ps
`default_nettype none

module fc_mac (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    step,
    input  wire                    first,
    input  wire                    last,
    input  wire  fc_pkg::quad_t    feat,
    input  wire  fc_pkg::quad_t    wgt,
    input  wire  fc_pkg::bias_t    bias,
    input  wire  fc_pkg::shift_t   shift,
    input  wire                    relu_en,
    output logic                   res_valid,
    output fc_pkg::int8_t          res_data
);

    // Flags delayed to line up with memory read data
    logic s0_step;
    logic s0_first;
    logic s0_last;

    // Stage one
    logic          p_step;
    logic          p_first;
    logic          p_last;
    fc_pkg::acc_t  p_sum;
    fc_pkg::bias_t p_bias;
    fc_pkg::acc_t  lane_sum;

    // Stage two
    fc_pkg::acc_t  acc;
    fc_pkg::acc_t  acc_next;
    fc_pkg::acc_t  shifted;
    fc_pkg::int8_t sat;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s0_step  <= 1'b0;
            s0_first <= 1'b0;
            s0_last  <= 1'b0;
            p_step   <= 1'b0;
            p_first  <= 1'b0;
            p_last   <= 1'b0;
        end else begin
            s0_step  <= step;
            s0_first <= first;
            s0_last  <= last;
            p_step   <= s0_step;
            p_first  <= s0_first;
            p_last   <= s0_last;
        end
    end

    // Four signed 8x8 products summed across the lanes
    always_comb begin
        lane_sum = '0;
        for (int l = 0; l < fc_pkg::LANES; l++) begin
            lane_sum = lane_sum + fc_pkg::acc_t'(feat[l]) * fc_pkg::acc_t'(wgt[l]);
        end
    end

    always_ff @(posedge clk) begin
        if (s0_step) begin
            p_sum  <= lane_sum;
            p_bias <= bias;
        end
    end

    // Accumulate, then requantize the final sum
    always_comb begin
        acc_next = (p_first ? fc_pkg::acc_t'(0) : acc) + p_sum;
        if (p_last) begin
            acc_next = acc_next + fc_pkg::acc_t'(p_bias);
        end
        shifted = acc_next >>> shift;
        if (relu_en && (shifted < 0)) begin
            shifted = '0;
        end
        if (shifted > fc_pkg::acc_t'(127)) begin
            sat = 8'sd127;
        end else if (shifted < fc_pkg::acc_t'(-128)) begin
            sat = -8'sd128;
        end else begin
            sat = shifted[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (p_step) begin
            acc <= acc_next;
        end
        if (p_step && p_last) begin
            res_data <= sat;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= p_step && p_last;
        end
    end

    // Sequencer must mark word boundaries only on issued words
    a_flags_need_step: assert property (@(posedge clk) disable iff (!rstn)
        (first || last) |-> step)
        else $error("fc_mac first or last raised without step");

endmodule

`default_nettype wire

//--- fc_argmax.sv
`timescale 1ns/1ps
`default_nettype none

module fc_argmax (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire                  clear,
    input  wire                  beat,
    input  wire  fc_pkg::int8_t  value,
    input  wire  [7:0]           index,
    input  wire                  last,
    output logic                 class_valid,
    output logic [7:0]           class_id
);

    fc_pkg::int8_t best_val;
    logic          take;

    // Strictly greater keeps the lowest index on a tie
    assign take = beat && ((index == 8'd0) || (value > best_val));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            best_val    <= -8'sd128;
            class_id    <= 8'd0;
            class_valid <= 1'b0;
        end else begin
            if (take) begin
                best_val <= value;
                class_id <= index;
            end
            // Held until the next run starts
            if (clear) begin
                class_valid <= 1'b0;
            end else if (beat && last) begin
                class_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- fc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fc_sequencer #(
    parameter int N_IN  = 16,
    parameter int N_OUT = 10
) (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire                       start_valid,
    output logic                      start_ready,
    output logic                      feat_rd_en,
    output logic [fc_pkg::ADDR_W-1:0] feat_rd_addr,
    output logic                      wgt_rd_en,
    output logic [fc_pkg::ADDR_W-1:0] wgt_rd_addr,
    output logic                      bias_rd_en,
    output logic [fc_pkg::ADDR_W-1:0] bias_rd_addr,
    output logic                      mac_step,
    output logic                      mac_first,
    output logic                      mac_last,
    input  wire                       res_valid,
    input  wire  fc_pkg::int8_t       res_data,
    output logic                      out_valid,
    output fc_pkg::int8_t             out_data,
    output logic [7:0]                out_index,
    input  wire                       out_ready,
    output logic                      run_clear,
    output logic                      beat,
    output logic                      beat_last
);

    localparam int AW    = fc_pkg::ADDR_W;
    localparam int WORDS = N_IN / fc_pkg::LANES;

    localparam logic [AW-1:0] WORDS_A     = AW'(WORDS);
    localparam logic [AW-1:0] LAST_WORD   = AW'(WORDS - 1);
    localparam logic [7:0]    LAST_NEURON = 8'(N_OUT - 1);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ISSUE = 2'd1,
        DRAIN = 2'd2
    } state_t;

    state_t        state;
    logic [AW-1:0] word_cnt;
    logic [7:0]    neuron_cnt;
    logic [7:0]    res_cnt;
    logic [1:0]    pend_cnt;
    logic [2:0]    occ;
    logic          start_fire;
    logic          accept;
    logic          can_start;
    logic          issue;
    logic          word_last;

    logic          skid_valid;
    fc_pkg::int8_t skid_data;
    logic [7:0]    skid_index;
    logic          out_load;
    logic          skid_load;

    assign start_ready = (state == IDLE);
    assign start_fire  = start_valid && start_ready;
    assign run_clear   = start_fire;
    assign accept      = out_valid && out_ready;

    // Results owed or held, never more than output register plus skid slot
    assign occ       = {1'b0, pend_cnt} + {2'b00, out_valid} + {2'b00, skid_valid};
    assign can_start = (occ - {2'b00, accept}) < 3'd2;

    // Once a neuron starts its words go out back to back
    assign issue     = (state == ISSUE) && ((word_cnt != '0) || can_start);
    assign word_last = (word_cnt == LAST_WORD);

    assign mac_step  = issue;
    assign mac_first = issue && (word_cnt == '0);
    assign mac_last  = issue && word_last;

    assign feat_rd_en   = issue;
    assign feat_rd_addr = word_cnt;
    assign wgt_rd_en    = issue;
    assign wgt_rd_addr  = AW'(neuron_cnt) * WORDS_A + word_cnt;
    assign bias_rd_en   = issue && word_last;
    assign bias_rd_addr = AW'(neuron_cnt);

    assign beat      = accept;
    assign beat_last = accept && (out_index == LAST_NEURON);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= IDLE;
            word_cnt   <= '0;
            neuron_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_fire) begin
                        state      <= ISSUE;
                        word_cnt   <= '0;
                        neuron_cnt <= '0;
                    end
                end
                ISSUE: begin
                    if (issue) begin
                        if (word_last) begin
                            word_cnt <= '0;
                            if (neuron_cnt == LAST_NEURON) begin
                                state <= DRAIN;
                            end else begin
                                neuron_cnt <= neuron_cnt + 8'd1;
                            end
                        end else begin
                            word_cnt <= word_cnt + AW'(1);
                        end
                    end
                end
                DRAIN: begin
                    if (beat_last) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Neurons in the MAC and result index
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pend_cnt <= '0;
            res_cnt  <= '0;
        end else begin
            case ({mac_first, res_valid})
                2'b10:   pend_cnt <= pend_cnt + 2'd1;
                2'b01:   pend_cnt <= pend_cnt - 2'd1;
                default: pend_cnt <= pend_cnt;
            endcase
            if (start_fire) begin
                res_cnt <= '0;
            end else if (res_valid) begin
                res_cnt <= res_cnt + 8'd1;
            end
        end
    end

    // Skid entry moves up first, new results take whichever slot is free
    always_comb begin
        out_load  = 1'b0;
        skid_load = 1'b0;
        if (skid_valid) begin
            out_load = accept;
        end else if (res_valid) begin
            if (!out_valid || accept) begin
                out_load = 1'b1;
            end else begin
                skid_load = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (out_load) begin
                out_valid <= 1'b1;
            end else if (accept) begin
                out_valid <= 1'b0;
            end
            if (skid_load) begin
                skid_valid <= 1'b1;
            end else if (accept) begin
                skid_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            out_data  <= skid_valid ? skid_data : res_data;
            out_index <= skid_valid ? skid_index : res_cnt;
        end
        if (skid_load) begin
            skid_data  <= res_data;
            skid_index <= res_cnt;
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (!rstn)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_index)))
        else $error("fc_sequencer output changed while stalled");

    // Issue gating must keep the MAC from delivering into a full skid slot
    a_skid_no_overrun: assert property (@(posedge clk) disable iff (!rstn)
        skid_valid |-> !res_valid)
        else $error("fc_sequencer result arrived with skid slot full");

endmodule

`default_nettype wire

//--- fc_top.sv
`timescale 1ns/1ps
`default_nettype none

module fc_top #(
    parameter int N_IN  = 16,
    parameter int N_OUT = 10
) (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire                       load_valid,
    output logic                      load_ready,
    input  wire  fc_pkg::mem_sel_t    load_sel,
    input  wire  [fc_pkg::ADDR_W-1:0] load_addr,
    input  wire  [31:0]               load_data,
    input  wire                       start_valid,
    output logic                      start_ready,
    input  wire  fc_pkg::shift_t      shift,
    input  wire                       relu_en,
    output logic                      out_valid,
    input  wire                       out_ready,
    output fc_pkg::int8_t             out_data,
    output logic [7:0]                out_index,
    output logic                      class_valid,
    output logic [7:0]                class_id
);

    localparam int AW         = fc_pkg::ADDR_W;
    localparam int FEAT_DEPTH = N_IN / fc_pkg::LANES;
    localparam int WGT_DEPTH  = N_OUT * FEAT_DEPTH;
    localparam int BIAS_DEPTH = N_OUT;

    logic           load_fire;
    logic           feat_wr_en;
    logic           wgt_wr_en;
    logic           bias_wr_en;

    logic           feat_rd_en;
    logic [AW-1:0]  feat_rd_addr;
    fc_pkg::quad_t  feat_rd_data;
    logic           wgt_rd_en;
    logic [AW-1:0]  wgt_rd_addr;
    fc_pkg::quad_t  wgt_rd_data;
    logic           bias_rd_en;
    logic [AW-1:0]  bias_rd_addr;
    fc_pkg::bias_t  bias_rd_data;

    logic           mac_step;
    logic           mac_first;
    logic           mac_last;
    logic           res_valid;
    fc_pkg::int8_t  res_data;
    logic           run_clear;
    logic           beat;
    logic           beat_last;

    fc_pkg::shift_t run_shift;
    logic           run_relu;

    // Memories only take host writes between runs
    assign load_ready = start_ready;
    assign load_fire  = load_valid && load_ready;
    assign feat_wr_en = load_fire && (load_sel == fc_pkg::SEL_FEATURE);
    assign wgt_wr_en  = load_fire && (load_sel == fc_pkg::SEL_WEIGHT);
    assign bias_wr_en = load_fire && (load_sel == fc_pkg::SEL_BIAS);

    // Run settings captured on the start handshake
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run_shift <= '0;
            run_relu  <= 1'b0;
        end else if (start_valid && start_ready) begin
            run_shift <= shift;
            run_relu  <= relu_en;
        end
    end

    fc_mem #(.DEPTH(FEAT_DEPTH), .word_t(fc_pkg::quad_t)) u_feat_mem (
        .clk     (clk),
        .wr_en   (feat_wr_en),
        .wr_addr (load_addr),
        .wr_data (load_data),
        .rd_en   (feat_rd_en),
        .rd_addr (feat_rd_addr),
        .rd_data (feat_rd_data)
    );

    fc_mem #(.DEPTH(WGT_DEPTH), .word_t(fc_pkg::quad_t)) u_wgt_mem (
        .clk     (clk),
        .wr_en   (wgt_wr_en),
        .wr_addr (load_addr),
        .wr_data (load_data),
        .rd_en   (wgt_rd_en),
        .rd_addr (wgt_rd_addr),
        .rd_data (wgt_rd_data)
    );

    // Bias sits in the low half of the load word
    fc_mem #(.DEPTH(BIAS_DEPTH), .word_t(fc_pkg::bias_t)) u_bias_mem (
        .clk     (clk),
        .wr_en   (bias_wr_en),
        .wr_addr (load_addr),
        .wr_data (fc_pkg::bias_t'(load_data[15:0])),
        .rd_en   (bias_rd_en),
        .rd_addr (bias_rd_addr),
        .rd_data (bias_rd_data)
    );

    fc_sequencer #(.N_IN(N_IN), .N_OUT(N_OUT)) u_seq (
        .clk          (clk),
        .rstn         (rstn),
        .start_valid  (start_valid),
        .start_ready  (start_ready),
        .feat_rd_en   (feat_rd_en),
        .feat_rd_addr (feat_rd_addr),
        .wgt_rd_en    (wgt_rd_en),
        .wgt_rd_addr  (wgt_rd_addr),
        .bias_rd_en   (bias_rd_en),
        .bias_rd_addr (bias_rd_addr),
        .mac_step     (mac_step),
        .mac_first    (mac_first),
        .mac_last     (mac_last),
        .res_valid    (res_valid),
        .res_data     (res_data),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_index    (out_index),
        .out_ready    (out_ready),
        .run_clear    (run_clear),
        .beat         (beat),
        .beat_last    (beat_last)
    );

    fc_mac u_mac (
        .clk       (clk),
        .rstn      (rstn),
        .step      (mac_step),
        .first     (mac_first),
        .last      (mac_last),
        .feat      (feat_rd_data),
        .wgt       (wgt_rd_data),
        .bias      (bias_rd_data),
        .shift     (run_shift),
        .relu_en   (run_relu),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

    fc_argmax u_argmax (
        .clk         (clk),
        .rstn        (rstn),
        .clear       (run_clear),
        .beat        (beat),
        .value       (out_data),
        .index       (out_index),
        .last        (beat_last),
        .class_valid (class_valid),
        .class_id    (class_id)
    );

endmodule

`default_nettype wire

//--- tb_fc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fc_top;

    localparam int N_IN     = 16;
    localparam int N_OUT    = 10;
    localparam int RUNS     = 3;
    localparam int F_WORDS  = N_IN / 4;
    localparam int W_WORDS  = N_OUT * F_WORDS;
    // Each run holds config, features, weights, biases, expected outputs and class
    localparam int RUN_LEN  = 1 + F_WORDS + W_WORDS + N_OUT + N_OUT + 1;
    localparam int OFS_FEAT = 1;
    localparam int OFS_WGT  = OFS_FEAT + F_WORDS;
    localparam int OFS_BIAS = OFS_WGT + W_WORDS;
    localparam int OFS_EXP  = OFS_BIAS + N_OUT;
    localparam int OFS_CLS  = OFS_EXP + N_OUT;
    // Worst case random stalls plus loading plus margin
    localparam int MAX_CYCLES = RUNS * (N_OUT * F_WORDS + N_OUT) * 8 + RUNS * RUN_LEN + 10 + 200;

    logic                     clk;
    logic                     rstn;
    logic                     load_valid;
    logic                     load_ready;
    fc_pkg::mem_sel_t         load_sel;
    logic [fc_pkg::ADDR_W-1:0] load_addr;
    logic [31:0]              load_data;
    logic                     start_valid;
    logic                     start_ready;
    fc_pkg::shift_t           shift;
    logic                     relu_en;
    logic                     out_valid;
    logic                     out_ready;
    fc_pkg::int8_t            out_data;
    logic [7:0]               out_index;
    logic                     class_valid;
    logic [7:0]               class_id;

    logic [31:0] vec [RUNS * RUN_LEN];
    integer      seed;
    int          err_cnt;
    int          chk_cnt;
    int          cycle_cnt;

    fc_top #(.N_IN(N_IN), .N_OUT(N_OUT)) u_fc_top (
        .clk         (clk),
        .rstn        (rstn),
        .load_valid  (load_valid),
        .load_ready  (load_ready),
        .load_sel    (load_sel),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .shift       (shift),
        .relu_en     (relu_en),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .out_index   (out_index),
        .class_valid (class_valid),
        .class_id    (class_id)
    );

    always #50 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("Timeout after %0d cycles, DUT stopped responding", cycle_cnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_out(input fc_pkg::int8_t got, input fc_pkg::int8_t exp,
                             input logic [7:0] got_idx, input logic [7:0] exp_idx);
        chk_cnt++;
        if (got_idx !== exp_idx) begin
            err_cnt++;
            $display("ERR out_index: got %h exp %h", got_idx, exp_idx);
        end
        if (got !== exp) begin
            err_cnt++;
            $display("ERR out_data[%0d]: got %h exp %h", exp_idx, got, exp);
        end
    endtask

    task automatic check_class(input logic [7:0] got, input logic [7:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR class_id: got %h exp %h", got, exp);
        end
    endtask

    task automatic report(input string what);
        err_cnt++;
        $display("%s", what);
    endtask

    task automatic load_word(input fc_pkg::mem_sel_t sel, input int addr, input logic [31:0] data);
        @(negedge clk);
        if (!load_ready) begin
            report("Load port not ready between runs");
        end
        load_valid = 1'b1;
        load_sel   = sel;
        load_addr  = addr[fc_pkg::ADDR_W-1:0];
        load_data  = data;
        @(posedge clk);
    endtask

    task automatic load_run(input int base);
        for (int k = 0; k < F_WORDS; k++) begin
            load_word(fc_pkg::SEL_FEATURE, k, vec[base + OFS_FEAT + k]);
        end
        for (int k = 0; k < W_WORDS; k++) begin
            load_word(fc_pkg::SEL_WEIGHT, k, vec[base + OFS_WGT + k]);
        end
        for (int k = 0; k < N_OUT; k++) begin
            load_word(fc_pkg::SEL_BIAS, k, vec[base + OFS_BIAS + k]);
        end
        @(negedge clk);
        load_valid = 1'b0;
    endtask

    task automatic start_run(input logic [31:0] cfg, input logic class_held);
        @(negedge clk);
        if (!start_ready) begin
            report("Start not ready while idle");
        end
        // Previous result stays up until this start is taken
        if (class_valid !== class_held) begin
            report("class_valid wrong before the start was accepted");
        end
        start_valid = 1'b1;
        shift       = cfg[3:0];
        relu_en     = cfg[8];
        @(posedge clk);
        @(negedge clk);
        start_valid = 1'b0;
        if (class_valid) begin
            report("class_valid still high after start");
        end
    endtask

    task automatic collect_run(input int base);
        int            got;
        logic          stalled;
        fc_pkg::int8_t held_data;
        logic [7:0]    held_idx;
        logic [31:0]   r;
        got     = 0;
        stalled = 1'b0;
        while (got < N_OUT) begin
            @(negedge clk);
            if (load_ready || start_ready) begin
                report("Load or start ready during a run");
            end
            // A stalled beat must keep its data
            if (stalled) begin
                if (!out_valid) begin
                    report("out_valid dropped before the beat was accepted");
                end else if (out_data !== held_data || out_index !== held_idx) begin
                    err_cnt++;
                    $display("ERR out_data held: got %h/%h exp %h/%h",
                             out_data, out_index, held_data, held_idx);
                end
            end
            r = $random(seed);
            out_ready = r[0];
            if (out_valid && out_ready) begin
                check_out(out_data, fc_pkg::int8_t'(vec[base + OFS_EXP + got][7:0]),
                          out_index, 8'(got));
                got++;
                stalled = 1'b0;
            end else if (out_valid) begin
                stalled   = 1'b1;
                held_data = out_data;
                held_idx  = out_index;
            end
        end
        @(negedge clk);
        out_ready = 1'b0;
        while (!class_valid) begin
            @(negedge clk);
        end
        check_class(class_id, vec[base + OFS_CLS][7:0]);
        if (!load_ready || !start_ready) begin
            report("Load or start not ready after class_valid");
        end
        if (out_valid) begin
            report("Extra output beat after the last neuron");
        end
    endtask

    initial begin
        clk         = 1'b0;
        rstn        = 1'b0;
        load_valid  = 1'b0;
        load_sel    = fc_pkg::SEL_FEATURE;
        load_addr   = '0;
        load_data   = '0;
        start_valid = 1'b0;
        shift       = '0;
        relu_en     = 1'b0;
        out_ready   = 1'b0;
        seed        = 32'h9941_6c6a;
        err_cnt     = 0;
        chk_cnt     = 0;
        $readmemh("fc_vectors.mem", vec);

        repeat (10) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        if (!load_ready || !start_ready || out_valid || class_valid) begin
            report("Handshake state wrong after reset");
        end

        for (int run = 0; run < RUNS; run++) begin
            load_run(run * RUN_LEN);
            start_run(vec[run * RUN_LEN], run > 0);
            collect_run(run * RUN_LEN);
        end

        $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fc_vectors.mem
// Per run: config {relu bit 8, shift bits 3:0}, 4 feature words, 40 weight words
// (4 per neuron), 10 biases, 10 expected outputs (low byte), expected class
// Run 1: relu off, shift 4
00000004
04030201 08070605 FCFDFEFF 00000000
01010101 01010101 01010101 01010101
02020202 00000000 00000000 00000000
00000000 02020202 00000000 00000000
FFFFFFFF FFFFFFFF 00000000 00000000
00000000 00000000 03030303 00000000
04040404 04040404 00000000 00000000
00000000 00000000 00000000 05050505
03030303 00000000 00000000 00000000
01010101 02020202 01010101 00000000
00000000 FDFDFDFD 00000000 00000000
00000000 00000010 0000FFFC 00000000 00000000 00000064 0000FF60 00000002 00000008 00000005
00000001 00000002 00000003 000000FD 000000FE 0000000F 000000F6 00000002 00000003 000000FB
00000005
// Run 2: relu on, shift 2
00000102
02020202 01010101 FFFFFFFF 03030303
01010101 00000000 00000000 00000000
FFFFFFFF 00000000 00000000 00000000
00000000 00000000 01010101 00000000
00000000 00000000 00000000 01010101
00000000 00000000 00000000 FFFFFFFF
01010101 01010101 01010101 01010101
02020202 00000000 00000000 00000000
00000000 05050505 00000000 00000000
00000000 00000000 00000000 02020202
00000000 01010101 00000000 00000000
00000000 00000000 00000000 00000004 00000000 00000000 00000001 0000FFFF 0000FFE2 00000002
00000002 00000000 00000000 00000004 00000000 00000005 00000004 00000004 00000000 00000001
00000005
// Run 3: relu off, shift 0, saturation and a tie at 127
00000000
7F7F7F7F 01010101 80808080 00000000
01010101 00000000 00000000 00000000
00000000 00000000 01010101 00000000
00000000 01010101 00000000 00000000
00000000 0A0A0A0A 00000000 00000000
7F7F7F7F 00000000 00000000 00000000
80808080 00000000 00000000 00000000
00000000 FBFBFBFB 00000000 00000000
00000000 00000000 00000000 64646464
00000000 00000000 FFFFFFFF 00000000
00000000 20202020 00000000 00000000
00000000 00000000 00000003 00000000 00000000 00000000 00000000 0000FF9C 0000FC18 0000FFFF
0000007F 00000080 00000007 00000028 0000007F 00000080 000000EC 0000009C 00000080 0000007F
00000000

//--- build.f
fc_pkg.sv
fc_mem.sv
fc_mac.sv
fc_argmax.sv
fc_sequencer.sv
fc_top.sv
tb_fc_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fc_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "No result in log"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
